// File: logic/fire_pkg.sv
`default_nettype none

package fire_pkg;

	// ------------------------------------------------
	// widths and counts
	// ------------------------------------------------
	localparam int DATA_W    = 16; // signed q8.8
	localparam int FRAC_BITS = 8;
	localparam int ACC_W     = 40; // headroom for 9 * 63 products
	localparam int CNT_W     = 6;
	localparam int TAPS_E3   = 9;
	localparam int TAPS_E1   = 1;
	localparam int CMD_DEPTH = 4;
	localparam int CMD_PTR_W = $clog2(CMD_DEPTH);
	localparam int CMD_OCC_W = $clog2(CMD_DEPTH + 1);
	localparam int BEAT_W    = 10; // up to 9 * 63 beats per job
	localparam int SAT_MAX   = 2 ** (DATA_W - 1) - 1;

	typedef logic signed [DATA_W-1:0] data_t;
	typedef logic signed [ACC_W-1:0]  acc_t;
	typedef logic [CNT_W-1:0]         count_t;
	typedef logic [BEAT_W-1:0]        beat_t;
	typedef logic [CMD_PTR_W-1:0]     cmd_ptr_t;
	typedef logic [CMD_OCC_W-1:0]     cmd_occ_t;

	typedef enum logic [0:0] {
		OP_CONV    = 1'b0,
		OP_MAXPOOL = 1'b1
	} op_t;

	// ------------------------------------------------
	// streams
	// ------------------------------------------------
	typedef struct packed {
		op_t    op;
		count_t op_num;  // input channels, never zero
		data_t  bias_e3;
		data_t  bias_e1;
	} cmd_t;

	typedef struct packed {
		data_t data;
		data_t weight;
	} operand_t;

	typedef struct packed {
		data_t e3; // upper half
		data_t e1;
	} result_t;

	typedef enum logic [1:0] {
		SEQ_WAIT  = 2'd0,
		SEQ_START = 2'd1
	} seq_state_t;

	typedef enum logic [1:0] {
		LANE_IDLE  = 2'd0,
		LANE_ACC   = 2'd1,
		LANE_OFFER = 2'd2
	} lane_state_t;

	typedef enum logic [1:0] {
		MERGE_IDLE = 2'd0,
		MERGE_WAIT = 2'd1,
		MERGE_CALC = 2'd2,
		MERGE_OUT  = 2'd3
	} merge_state_t;

endpackage

`default_nettype wire

// File: logic/cmd_fifo.sv
`default_nettype none

module cmd_fifo (
	input  wire                   okClk,
	input  wire                   rst_n,
	input  wire  fire_pkg::cmd_t  in_cmd,
	input  wire                   in_valid,
	output logic                  in_ready,
	output fire_pkg::cmd_t        out_cmd,
	output logic                  out_valid,
	input  wire                   out_ready
);

	fire_pkg::cmd_t   mem [fire_pkg::CMD_DEPTH];
	fire_pkg::cmd_ptr_t wr_ptr;
	fire_pkg::cmd_ptr_t rd_ptr;
	fire_pkg::cmd_occ_t occ;
	logic push;
	logic pop;

	assign in_ready  = (occ != fire_pkg::cmd_occ_t'(fire_pkg::CMD_DEPTH)); // low only when full
	assign out_valid = (occ != '0);
	assign out_cmd   = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	// command storage
	always_ff @(posedge okClk) begin
		if (push) begin
			mem[wr_ptr] <= in_cmd;
		end
	end

	// ------------------------------------------------
	// pointers and occupancy
	// ------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ    <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == fire_pkg::cmd_ptr_t'(fire_pkg::CMD_DEPTH - 1)) begin
					wr_ptr <= '0; // wrap
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (pop) begin
				if (rd_ptr == fire_pkg::cmd_ptr_t'(fire_pkg::CMD_DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			case ({push, pop})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/job_sequencer.sv
`default_nettype none

module job_sequencer (
	input  wire                   okClk,
	input  wire                   rst_n,
	input  wire  fire_pkg::cmd_t  q_cmd,
	input  wire                   q_valid,
	output logic                  q_ready,
	input  wire                   e3_idle,
	input  wire                   e1_idle,
	input  wire                   merge_idle,
	output fire_pkg::cmd_t        job,
	output logic                  job_start
);

	fire_pkg::seq_state_t state;
	logic all_idle;
	logic pop;

	// units only leave idle on job_start, so checking here is enough
	assign all_idle = e3_idle && e1_idle && merge_idle;
	assign q_ready  = (state == fire_pkg::SEQ_WAIT) && all_idle;
	assign pop      = q_valid && q_ready;

	assign job_start = (state == fire_pkg::SEQ_START); // one cycle pulse

	// ------------------------------------------------
	// control
	// ------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			state <= fire_pkg::SEQ_WAIT;
		end else begin
			case (state)
				fire_pkg::SEQ_WAIT: begin
					if (pop) begin
						state <= fire_pkg::SEQ_START;
					end
				end
				fire_pkg::SEQ_START: begin
					state <= fire_pkg::SEQ_WAIT; // receivers busy from next cycle
				end
				default: begin
					state <= fire_pkg::SEQ_WAIT;
				end
			endcase
		end
	end

	// popped command, held for the lanes and merge
	always_ff @(posedge okClk) begin
		if (pop) begin
			job <= q_cmd;
		end
	end

endmodule

`default_nettype wire

// File: logic/expand_lane.sv
`default_nettype none

module expand_lane #(
	parameter int TAPS = 1
) (
	input  wire                      okClk,
	input  wire                      rst_n,
	input  wire  fire_pkg::cmd_t     job,
	input  wire                      job_start,
	output logic                     idle,
	input  wire  fire_pkg::operand_t operand,
	input  wire                      operand_valid,
	output logic                     operand_ready,
	output fire_pkg::acc_t           lane_result,
	output logic                     lane_valid,
	input  wire                      lane_ready
);

	fire_pkg::lane_state_t state;
	fire_pkg::op_t         op_q;
	fire_pkg::beat_t       beat_target;
	fire_pkg::beat_t       beat_cnt;
	fire_pkg::acc_t        acc;
	fire_pkg::data_t       beat_data;
	fire_pkg::data_t       beat_weight;
	logic signed [2*fire_pkg::DATA_W-1:0] product;
	fire_pkg::acc_t        product_ext;
	fire_pkg::acc_t        data_ext;
	logic take;
	logic last_beat;

	assign beat_data   = operand.data;
	assign beat_weight = operand.weight;
	assign product     = beat_data * beat_weight; // full q16.16 product
	assign product_ext = fire_pkg::acc_t'(product);
	assign data_ext    = fire_pkg::acc_t'(beat_data);

	assign idle          = (state == fire_pkg::LANE_IDLE);
	assign operand_ready = (state == fire_pkg::LANE_ACC);
	assign lane_valid    = (state == fire_pkg::LANE_OFFER);
	assign lane_result   = acc;

	assign take      = operand_valid && operand_ready;
	assign last_beat = (beat_cnt == beat_target - 1'b1);

	// ------------------------------------------------
	// beat counting
	// ------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			state    <= fire_pkg::LANE_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				fire_pkg::LANE_IDLE: begin
					if (job_start) begin
						state    <= fire_pkg::LANE_ACC;
						beat_cnt <= '0;
					end
				end
				fire_pkg::LANE_ACC: begin
					if (take) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (last_beat) begin
							state <= fire_pkg::LANE_OFFER;
						end
					end
				end
				fire_pkg::LANE_OFFER: begin
					if (lane_ready) begin
						state <= fire_pkg::LANE_IDLE; // hold result until merge takes it
					end
				end
				default: begin
					state <= fire_pkg::LANE_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------
	// datapath
	// ------------------------------------------------
	always_ff @(posedge okClk) begin
		if (job_start) begin
			op_q        <= job.op;
			beat_target <= fire_pkg::beat_t'(TAPS) * fire_pkg::beat_t'(job.op_num);
			acc         <= '0;
		end else if (take) begin
			if (op_q == fire_pkg::OP_MAXPOOL) begin
				if (beat_cnt == '0 || data_ext > acc) begin
					acc <= data_ext; // first beat loads, weight ignored
				end
			end else begin
				acc <= acc + product_ext;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/expand_merge.sv
`default_nettype none

module expand_merge (
	input  wire                     okClk,
	input  wire                     rst_n,
	input  wire  fire_pkg::cmd_t    job,
	input  wire                     job_start,
	output logic                    idle,
	input  wire  fire_pkg::acc_t    e3_result,
	input  wire  fire_pkg::acc_t    e1_result,
	input  wire                     e3_valid,
	input  wire                     e1_valid,
	output logic                    e3_ready,
	output logic                    e1_ready,
	output fire_pkg::result_t       result,
	output logic                    result_valid,
	input  wire                     result_ready
);

	fire_pkg::merge_state_t state;
	fire_pkg::op_t          op_q;
	fire_pkg::data_t        bias_e3_q;
	fire_pkg::data_t        bias_e1_q;
	fire_pkg::acc_t         e3_raw;
	fire_pkg::acc_t         e1_raw;
	fire_pkg::result_t      result_q;
	logic both_valid;

	function automatic fire_pkg::data_t finish_half(
		input fire_pkg::op_t   op,
		input fire_pkg::acc_t  raw,
		input fire_pkg::data_t bias
	);
		fire_pkg::acc_t biased;
		fire_pkg::acc_t scaled;
		biased = raw + (fire_pkg::acc_t'(bias) <<< fire_pkg::FRAC_BITS); // bias up to q16.16
		scaled = biased >>> fire_pkg::FRAC_BITS;
		if (op == fire_pkg::OP_MAXPOOL) begin
			return raw[fire_pkg::DATA_W-1:0]; // max passes through untouched
		end
		if (scaled < 0) begin
			return '0; // relu
		end
		if (scaled > fire_pkg::acc_t'(fire_pkg::SAT_MAX)) begin
			return fire_pkg::data_t'(fire_pkg::SAT_MAX);
		end
		return scaled[fire_pkg::DATA_W-1:0];
	endfunction

	assign both_valid   = e3_valid && e1_valid;
	assign idle         = (state == fire_pkg::MERGE_IDLE);
	assign e3_ready     = (state == fire_pkg::MERGE_WAIT) && both_valid; // release both together
	assign e1_ready     = (state == fire_pkg::MERGE_WAIT) && both_valid;
	assign result_valid = (state == fire_pkg::MERGE_OUT);
	assign result       = result_q;

	// ------------------------------------------------
	// control
	// ------------------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			state <= fire_pkg::MERGE_IDLE;
		end else begin
			case (state)
				fire_pkg::MERGE_IDLE: if (job_start) state <= fire_pkg::MERGE_WAIT;
				fire_pkg::MERGE_WAIT: if (both_valid) state <= fire_pkg::MERGE_CALC;
				fire_pkg::MERGE_CALC: state <= fire_pkg::MERGE_OUT;
				fire_pkg::MERGE_OUT:  if (result_ready) state <= fire_pkg::MERGE_IDLE;
				default:              state <= fire_pkg::MERGE_IDLE;
			endcase
		end
	end

	// job fields, lane captures and the output word
	always_ff @(posedge okClk) begin
		if (job_start) begin
			op_q      <= job.op;
			bias_e3_q <= job.bias_e3;
			bias_e1_q <= job.bias_e1;
		end
		if (e3_ready) begin
			e3_raw <= e3_result;
			e1_raw <= e1_result;
		end
		if (state == fire_pkg::MERGE_CALC) begin
			result_q.e3 <= finish_half(op_q, e3_raw, bias_e3_q);
			result_q.e1 <= finish_half(op_q, e1_raw, bias_e1_q);
		end
	end

endmodule

`default_nettype wire

// File: logic/fire_expand_top.sv
`default_nettype none

module fire_expand_top (
	input  wire                      okClk,
	input  wire                      rst_n,
	// command stream
	input  wire  fire_pkg::cmd_t     cmd,
	input  wire                      cmd_valid,
	output logic                     cmd_ready,
	// operand streams
	input  wire  fire_pkg::operand_t e3_operand,
	input  wire                      e3_valid,
	output logic                     e3_ready,
	input  wire  fire_pkg::operand_t e1_operand,
	input  wire                      e1_valid,
	output logic                     e1_ready,
	// result stream
	output fire_pkg::result_t        result,
	output logic                     result_valid,
	input  wire                      result_ready
);

	fire_pkg::cmd_t q_cmd;
	logic           q_valid;
	logic           q_ready;
	fire_pkg::cmd_t job;
	logic           job_start;
	logic           e3_idle;
	logic           e1_idle;
	logic           merge_idle;
	fire_pkg::acc_t e3_acc;
	fire_pkg::acc_t e1_acc;
	logic           e3_acc_valid;
	logic           e1_acc_valid;
	logic           e3_acc_ready;
	logic           e1_acc_ready;

	// ------------------------------------------------
	// command path
	// ------------------------------------------------
	cmd_fifo u_cmd_fifo (
		.okClk     (okClk),
		.rst_n     (rst_n),
		.in_cmd    (cmd),
		.in_valid  (cmd_valid),
		.in_ready  (cmd_ready),
		.out_cmd   (q_cmd),
		.out_valid (q_valid),
		.out_ready (q_ready)
	);

	job_sequencer u_job_sequencer (
		.okClk      (okClk),
		.rst_n      (rst_n),
		.q_cmd      (q_cmd),
		.q_valid    (q_valid),
		.q_ready    (q_ready),
		.e3_idle    (e3_idle),
		.e1_idle    (e1_idle),
		.merge_idle (merge_idle),
		.job        (job),
		.job_start  (job_start)
	);

	// ------------------------------------------------
	// expand lanes, side by side
	// ------------------------------------------------
	expand_lane #(.TAPS(fire_pkg::TAPS_E3)) u_lane_e3 (
		.okClk (okClk), .rst_n (rst_n),
		.job (job), .job_start (job_start), .idle (e3_idle),
		.operand (e3_operand), .operand_valid (e3_valid), .operand_ready (e3_ready),
		.lane_result (e3_acc), .lane_valid (e3_acc_valid), .lane_ready (e3_acc_ready)
	);

	expand_lane #(.TAPS(fire_pkg::TAPS_E1)) u_lane_e1 (
		.okClk (okClk), .rst_n (rst_n),
		.job (job), .job_start (job_start), .idle (e1_idle),
		.operand (e1_operand), .operand_valid (e1_valid), .operand_ready (e1_ready),
		.lane_result (e1_acc), .lane_valid (e1_acc_valid), .lane_ready (e1_acc_ready)
	);

	expand_merge u_merge (
		.okClk        (okClk),
		.rst_n        (rst_n),
		.job          (job),
		.job_start    (job_start),
		.idle         (merge_idle),
		.e3_result    (e3_acc),
		.e1_result    (e1_acc),
		.e3_valid     (e3_acc_valid),
		.e1_valid     (e1_acc_valid),
		.e3_ready     (e3_acc_ready),
		.e1_ready     (e1_acc_ready),
		.result       (result),
		.result_valid (result_valid),
		.result_ready (result_ready)
	);

endmodule

`default_nettype wire

// File: include/fire_vectors.svh
`ifndef FIRE_VECTORS_SVH
`define FIRE_VECTORS_SVH

// columns: op, op_num, bias_e3, bias_e1, then start, step and weight for the 3x3 lane
// and the 1x1 lane, back-pressure flag, expected e3 half, expected e1 half

localparam int NUM_VECTORS = 10;

vector_t vectors [NUM_VECTORS] = '{
	// small positive conv, biases 1.0 and 0.5
	'{fire_pkg::OP_CONV, 6'd1, 16'h0100, 16'h0080, 16'h0100, 16'h0010, 16'h0080,
		16'h0200, 16'h0000, 16'h0100, 1'b0, 16'h06a0, 16'h0280},
	'{fire_pkg::OP_CONV, 6'd2, 16'h0000, 16'hff00, 16'h0040, 16'h0008, 16'h0100,
		16'h0300, 16'h0100, 16'h0040, 1'b0, 16'h0948, 16'h00c0},
	// negative sums, relu to zero
	'{fire_pkg::OP_CONV, 6'd1, 16'h0000, 16'h0100, 16'hff00, 16'h0000, 16'h0100,
		16'h0100, 16'h0000, 16'hfe00, 1'b0, 16'h0000, 16'h0000},
	// overflow, saturate
	'{fire_pkg::OP_CONV, 6'd4, 16'h0100, 16'h0100, 16'h7f00, 16'h0000, 16'h7f00,
		16'h4000, 16'h0000, 16'h4000, 1'b0, 16'h7fff, 16'h7fff},
	// max-pool, mixed signs, biases ignored
	'{fire_pkg::OP_MAXPOOL, 6'd3, 16'h1234, 16'h5678, 16'h0500, 16'hff80, 16'h0333,
		16'h0180, 16'hff00, 16'h0777, 1'b0, 16'h0500, 16'h0180},
	'{fire_pkg::OP_MAXPOOL, 6'd1, 16'h0100, 16'h0100, 16'hf000, 16'h0180, 16'h0100,
		16'h8000, 16'h0000, 16'h0100, 1'b0, 16'hfc00, 16'h8000},
	// rows 0, 1 and 4 again under back-pressure
	'{fire_pkg::OP_CONV, 6'd1, 16'h0100, 16'h0080, 16'h0100, 16'h0010, 16'h0080,
		16'h0200, 16'h0000, 16'h0100, 1'b1, 16'h06a0, 16'h0280},
	'{fire_pkg::OP_CONV, 6'd2, 16'h0000, 16'hff00, 16'h0040, 16'h0008, 16'h0100,
		16'h0300, 16'h0100, 16'h0040, 1'b1, 16'h0948, 16'h00c0},
	'{fire_pkg::OP_MAXPOOL, 6'd3, 16'h1234, 16'h5678, 16'h0500, 16'hff80, 16'h0333,
		16'h0180, 16'hff00, 16'h0777, 1'b1, 16'h0500, 16'h0180},
	// largest channel count
	'{fire_pkg::OP_CONV, 6'd63, 16'h0000, 16'h0000, 16'h0001, 16'h0001, 16'h0001,
		16'h0010, 16'h0002, 16'h0100, 1'b0, 16'h0275, 16'h1332}
};

`endif

// File: verification/tb_fire_expand.sv
`default_nettype none

module tb_fire_expand;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 4000; // cycles per wait
	localparam logic [31:0] LFSR_SEED = 32'hf2a4bc6e;

	typedef struct packed {
		fire_pkg::op_t    op;
		fire_pkg::count_t op_num;
		fire_pkg::data_t  bias_e3;
		fire_pkg::data_t  bias_e1;
		fire_pkg::data_t  e3_start;
		fire_pkg::data_t  e3_step;
		fire_pkg::data_t  e3_weight;
		fire_pkg::data_t  e1_start;
		fire_pkg::data_t  e1_step;
		fire_pkg::data_t  e1_weight;
		logic             bp;
		fire_pkg::data_t  exp_e3;
		fire_pkg::data_t  exp_e1;
	} vector_t;

	`include "fire_vectors.svh"

	logic okClk;
	logic rst_n;
	fire_pkg::cmd_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	fire_pkg::operand_t e3_operand;
	logic e3_valid;
	logic e3_ready;
	fire_pkg::operand_t e1_operand;
	logic e1_valid;
	logic e1_ready;
	fire_pkg::result_t result;
	logic result_valid;
	logic result_ready;

	logic [31:0] lfsr_e3;
	logic [31:0] lfsr_e1;
	logic [31:0] lfsr_res;
	int results_done;

	fire_expand_top u_dut (
		.okClk (okClk), .rst_n (rst_n),
		.cmd (cmd), .cmd_valid (cmd_valid), .cmd_ready (cmd_ready),
		.e3_operand (e3_operand), .e3_valid (e3_valid), .e3_ready (e3_ready),
		.e1_operand (e1_operand), .e1_valid (e1_valid), .e1_ready (e1_ready),
		.result (result), .result_valid (result_valid), .result_ready (result_ready)
	);

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk; // 20 ns period
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'ha3000000; // galois taps 32,30,26,25
		end
		return s >> 1;
	endfunction

	function automatic fire_pkg::cmd_t make_cmd(input vector_t v);
		fire_pkg::cmd_t c;
		c.op      = v.op;
		c.op_num  = v.op_num;
		c.bias_e3 = v.bias_e3;
		c.bias_e1 = v.bias_e1;
		return c;
	endfunction

	task automatic step_cycle();
		@(posedge okClk);
		#2; // drive point
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("test failed");
		$fatal(1, "run stopped on timeout");
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("test failed");
			$fatal(1, "run stopped on mismatch");
		end
	endtask

	task automatic push_cmd(input fire_pkg::cmd_t c);
		int waited;
		waited    = 0;
		cmd       = c;
		cmd_valid = 1'b1;
		while (!cmd_ready) begin
			step_cycle();
			waited++;
			if (waited > WAIT_LIMIT) report_timeout("cmd_ready");
		end
		step_cycle(); // transfer on this edge
		cmd_valid = 1'b0;
	endtask

	task automatic send_operands(input bit lane_e3, input fire_pkg::data_t start,
		input fire_pkg::data_t step_v, input fire_pkg::data_t weight, input int beats,
		input bit bp);
		fire_pkg::operand_t beat;
		fire_pkg::data_t d;
		bit gap;
		int waited;
		d = start;
		for (int k = 0; k < beats; k++) begin
			gap = 1'b0;
			if (bp && lane_e3) begin
				gap     = lfsr_e3[0];
				lfsr_e3 = lfsr_step(lfsr_e3);
			end else if (bp) begin
				gap     = lfsr_e1[0];
				lfsr_e1 = lfsr_step(lfsr_e1);
			end
			if (gap) begin
				if (lane_e3) e3_valid = 1'b0;
				else e1_valid = 1'b0;
				step_cycle(); // one idle beat
			end
			beat.data   = d;
			beat.weight = weight;
			if (lane_e3) begin
				e3_operand = beat;
				e3_valid   = 1'b1;
			end else begin
				e1_operand = beat;
				e1_valid   = 1'b1;
			end
			waited = 0;
			while (!(lane_e3 ? e3_ready : e1_ready)) begin
				step_cycle();
				waited++;
				if (waited > WAIT_LIMIT) report_timeout(lane_e3 ? "e3_ready" : "e1_ready");
			end
			step_cycle();
			d = d + step_v;
		end
		if (lane_e3) e3_valid = 1'b0;
		else e1_valid = 1'b0;
	endtask

	task automatic collect_result(input bit bp, output fire_pkg::result_t got);
		int waited;
		bit done;
		bit rdy;
		waited = 0;
		done   = 1'b0;
		while (!done) begin
			rdy = 1'b1;
			if (bp) begin
				rdy      = lfsr_res[0]; // random stall
				lfsr_res = lfsr_step(lfsr_res);
			end
			result_ready = rdy;
			if (result_valid && rdy) begin
				got  = result;
				done = 1'b1;
			end
			step_cycle();
			waited++;
			if (!done && waited > WAIT_LIMIT) report_timeout("result_valid");
		end
		result_ready = 1'b0;
	endtask

	task automatic run_job(input vector_t v, input int row);
		fire_pkg::result_t got;
		fork
			send_operands(1'b1, v.e3_start, v.e3_step, v.e3_weight,
				fire_pkg::TAPS_E3 * int'(v.op_num), v.bp);
			send_operands(1'b0, v.e1_start, v.e1_step, v.e1_weight,
				fire_pkg::TAPS_E1 * int'(v.op_num), v.bp);
			collect_result(v.bp, got);
		join
		check_value($sformatf("result.e3 row %0d", row), got.e3, v.exp_e3);
		check_value($sformatf("result.e1 row %0d", row), got.e1, v.exp_e1);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		rst_n        = 1'b0;
		cmd          = '0;
		cmd_valid    = 1'b0;
		e3_operand   = '0;
		e3_valid     = 1'b0;
		e1_operand   = '0;
		e1_valid     = 1'b0;
		result_ready = 1'b0;
		lfsr_e3      = LFSR_SEED;
		lfsr_e1      = LFSR_SEED;
		lfsr_res     = LFSR_SEED;
		results_done = 0;

		repeat (10) @(posedge okClk);
		#2;
		rst_n = 1'b1;
		step_cycle();
		check_value("result_valid", 16'(result_valid), 16'h0000);
		check_value("e3_ready", 16'(e3_ready), 16'h0000);
		check_value("e1_ready", 16'(e1_ready), 16'h0000);
		check_value("cmd_ready", 16'(cmd_ready), 16'h0001);

		for (int i = 0; i < NUM_VECTORS; i++) begin // one job at a time
			push_cmd(make_cmd(vectors[i]));
			run_job(vectors[i], i);
		end

		// five commands fill the lanes and the queue
		for (int i = 0; i < 5; i++) begin
			push_cmd(make_cmd(vectors[i]));
		end
		check_value("cmd_ready when full", 16'(cmd_ready), 16'h0000);
		fork
			begin
				for (int i = 0; i < 6; i++) begin
					run_job(vectors[i], i);
					results_done++;
				end
			end
			begin
				push_cmd(make_cmd(vectors[5])); // held until an entry frees
				check_value("results before push", 16'(results_done >= 1), 16'h0001);
			end
		join

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
logic/fire_pkg.sv
logic/cmd_fifo.sv
logic/job_sequencer.sv
logic/expand_lane.sv
logic/expand_merge.sv
logic/fire_expand_top.sv
verification/tb_fire_expand.sv

// File: Makefile
# Verilator build and run for the fire expand testbench

VERILATOR ?= verilator
TOP       ?= tb_fire_expand
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
